/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_rom_cache
RTL_TOP ?= rom_cache
FILE_LIST ?= tb.f
BUILD_DIR ?= obj_dir
VERILATOR_FLAGS ?= --binary --timing -j 0
LINT_FLAGS ?= --lint-only -Wall
RTL_FILES ?= rom_cache_pkg.sv dual_port_ram.sv burst_buffer.sv burst_fetcher.sv rom_cache.sv
PASS_TEXT ?= all tests passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VERILATOR_FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) \
		-o V$(TOP) -f $(FILE_LIST)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

clean:
	rm -rf $(BUILD_DIR)

/* burst_buffer.sv */
module burst_buffer
	import rom_cache_pkg::*;
#(
	parameter int addr_width = buffer_addr_width_default
) (
	input  logic        clock,
	input  logic        reset,

	input  logic        wr,
	input  rom_word_t   data,

	input  logic        rd,
	input  logic        sprite_mode,
	output pixel_word_t q
);

	// four halfwords per 64-bit word, so the read side needs two more bits.
	localparam int index_width = addr_width + 2;

	logic [addr_width-1:0]  wr_ptr;
	logic [index_width-1:0] rd_ptr;
	logic [index_width-1:0] sprite_index;
	logic [index_width-1:0] rd_index;
	logic [addr_width-1:0]  ram_rd_addr;
	logic [1:0]             lane;
	logic [1:0]             lane_q;
	rom_word_t              ram_data;

	// a write starts a new burst, so reading restarts at halfword zero.
	// A read means the previous burst is being consumed, so the next write
	// lands at word zero again.
	always_ff @(posedge clock) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (wr) begin
				wr_ptr <= wr_ptr + 1'b1;
				rd_ptr <= '0;
			end
			if (rd) begin
				rd_ptr <= rd_ptr + 1'b1;
				wr_ptr <= '0;
			end
		end
	end

	// sprite ROMs are laid out so that one burst serves two pixel rows.
	// Swapping the low index bits around puts the halfwords back in
	// the order the sprite engine expects.
	assign sprite_index = {
		rd_ptr[index_width-1:6],
		~rd_ptr[1],
		rd_ptr[5:2],
		~rd_ptr[0]
	};

	assign rd_index    = sprite_mode ? sprite_index : rd_ptr;
	assign ram_rd_addr = rd_index[index_width-1:2];
	assign lane        = rd_index[1:0];

	dual_port_ram #(
		.addr_width (addr_width),
		.data_width ($bits(rom_word_t))
	) u_ram (
		.clock   (clock),
		.wr_en   (wr),
		.wr_addr (wr_ptr),
		.wr_data (data),
		.rd_addr (ram_rd_addr),
		.rd_data (ram_data)
	);

	// the RAM registers its read address, so the lane select is delayed
	// by the same edge to stay aligned with the word it picks from.
	always_ff @(posedge clock) begin
		lane_q <= lane;
	end

	always_comb begin
		case (lane_q)
			2'd0: q = ram_data[15:0];
			2'd1: q = ram_data[31:16];
			2'd2: q = ram_data[47:32];
			default: q = ram_data[63:48];
		endcase
	end

endmodule

/* burst_fetcher.sv */
module burst_fetcher
	import rom_cache_pkg::*;
#(
	parameter int burst_words = burst_words_default
) (
	input  logic      clock,
	input  logic      reset,

	input  logic      fetch_req,
	input  rom_addr_t fetch_addr,
	input  logic      fetch_sprite,
	output logic      busy,
	output logic      ready,

	output logic      mem_rd,
	output rom_addr_t mem_addr,
	input  logic      mem_valid,
	input  rom_word_t mem_data,

	output logic      buf_wr,
	output rom_word_t buf_data,
	output logic      sprite_mode
);

	localparam int count_width = (burst_words > 1) ? $clog2(burst_words) : 1;
	localparam logic [count_width-1:0] last_word = count_width'(burst_words - 1);

	fetch_state_t           state;
	fetch_state_t           state_next;
	logic [count_width-1:0] word_count;
	rom_addr_t              addr_q;
	logic                   sprite_q;
	logic                   accept;
	logic                   last_valid;

	// requests are taken only between bursts. One that arrives while a
	// burst is in flight is dropped and not queued.
	assign busy   = (state == fetch_request) || (state == fetch_receive);
	assign accept = fetch_req && !busy;

	assign last_valid = mem_valid && (word_count == last_word);

	always_comb begin
		state_next = state;
		case (state)
			fetch_idle, fetch_ready: begin
				if (accept) begin
					state_next = fetch_request;
				end
			end
			fetch_request: begin
				state_next = fetch_receive;
			end
			fetch_receive: begin
				if (last_valid) begin
					state_next = fetch_ready;
				end
			end
			default: begin
				state_next = fetch_idle;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= fetch_idle;
		end else begin
			state <= state_next;
		end
	end

	// the memory cannot be stalled, so every valid word in receive counts.
	always_ff @(posedge clock) begin
		if (reset) begin
			word_count <= '0;
		end else if (state == fetch_request) begin
			word_count <= '0;
		end else if (state == fetch_receive && mem_valid) begin
			word_count <= word_count + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			sprite_q <= 1'b0;
		end else if (accept) begin
			sprite_q <= fetch_sprite;
		end
	end

	always_ff @(posedge clock) begin
		if (accept) begin
			addr_q <= fetch_addr;
		end
	end

	assign mem_rd      = (state == fetch_request);
	assign mem_addr    = addr_q;
	assign ready       = (state == fetch_ready);
	assign buf_wr      = mem_valid && (state == fetch_receive);
	assign buf_data    = mem_data;
	assign sprite_mode = sprite_q;

endmodule

/* dual_port_ram.sv */
module dual_port_ram #(
	parameter int addr_width = 7,
	parameter int data_width = 64
) (
	input  logic                  clock,

	input  logic                  wr_en,
	input  logic [addr_width-1:0] wr_addr,
	input  logic [data_width-1:0] wr_data,

	input  logic [addr_width-1:0] rd_addr,
	output logic [data_width-1:0] rd_data
);

	localparam int depth = 1 << addr_width;

	logic [data_width-1:0] mem [depth];
	logic [addr_width-1:0] rd_addr_q;

	// write port.
	always_ff @(posedge clock) begin
		if (wr_en) begin
			mem[wr_addr] <= wr_data;
		end
	end

	// the read address is registered and the array is read from the
	// registered copy, so the data follows the address one edge later.
	// A read of a word that is written in the same cycle may give either value.
	always_ff @(posedge clock) begin
		rd_addr_q <= rd_addr;
	end

	assign rd_data = mem[rd_addr_q];

endmodule

/* rom_cache.sv */
module rom_cache
	import rom_cache_pkg::*;
#(
	parameter int burst_words       = burst_words_default,
	parameter int buffer_addr_width = buffer_addr_width_default
) (
	input  logic        clock,
	input  logic        reset,

	input  logic        fetch_req,
	input  rom_addr_t   fetch_addr,
	input  logic        fetch_sprite,
	output logic        busy,
	output logic        ready,

	output logic        mem_rd,
	output rom_addr_t   mem_addr,
	input  logic        mem_valid,
	input  rom_word_t   mem_data,

	input  logic        rd,
	output pixel_word_t q
);

	logic      buf_wr;
	rom_word_t buf_data;
	logic      sprite_mode;

	burst_fetcher #(
		.burst_words (burst_words)
	) u_fetcher (
		.clock        (clock),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_sprite (fetch_sprite),
		.busy         (busy),
		.ready        (ready),
		.mem_rd       (mem_rd),
		.mem_addr     (mem_addr),
		.mem_valid    (mem_valid),
		.mem_data     (mem_data),
		.buf_wr       (buf_wr),
		.buf_data     (buf_data),
		.sprite_mode  (sprite_mode)
	);

	// the buffer is sized for several bursts, and the read side drains
	// it in halfword order from word zero.
	burst_buffer #(
		.addr_width (buffer_addr_width)
	) u_buffer (
		.clock       (clock),
		.reset       (reset),
		.wr          (buf_wr),
		.data        (buf_data),
		.rd          (rd),
		.sprite_mode (sprite_mode),
		.q           (q)
	);

endmodule

/* rom_cache_pkg.sv */
package rom_cache_pkg;

	// one word as the memory returns it and as the buffer stores it.
	typedef logic [63:0] rom_word_t;

	// one halfword as the video side reads it.
	typedef logic [15:0] pixel_word_t;

	// address of a 64-bit word in ROM.
	typedef logic [21:0] rom_addr_t;

	// the fetcher waits in idle until the first request after reset.
	// Later it waits in ready, which keeps the buffer contents marked valid.
	typedef enum logic [1:0] {
		fetch_idle,
		fetch_request,
		fetch_receive,
		fetch_ready
	} fetch_state_t;

	// number of 64-bit words in one memory burst.
	localparam int burst_words_default = 16;

	// the buffer holds 1 << 7 = 128 words, which is 512 halfwords.
	localparam int buffer_addr_width_default = 7;

endpackage

/* rom_cache_stimulus.txt */
# fetch <rom word address, hex> <sprite 0/1> <second request while busy 0/1> <test name>
# read <eight expected halfwords in hex, in read order>
fetch 000100 0 0 first_tile_fetch
read 0400 0401 0402 0403 0404 0405 0406 0407
fetch 012345 0 0 tile_read_order
read 8D14 8D15 8D16 8D17 8D18 8D19 8D1A 8D1B
read 8D1C 8D1D 8D1E 8D1F 8D20 8D21 8D22 8D23
read 8D24 8D25 8D26 8D27 8D28 8D29 8D2A 8D2B
read 8D2C 8D2D 8D2E 8D2F 8D30 8D31 8D32 8D33
read 8D34 8D35 8D36 8D37 8D38 8D39 8D3A 8D3B
read 8D3C 8D3D 8D3E 8D3F 8D40 8D41 8D42 8D43
read 8D44 8D45 8D46 8D47 8D48 8D49 8D4A 8D4B
read 8D4C 8D4D 8D4E 8D4F 8D50 8D51 8D52 8D53
fetch 012345 1 0 sprite_read_order
read 8D35 8D34 8D15 8D14 8D37 8D36 8D17 8D16
read 8D39 8D38 8D19 8D18 8D3B 8D3A 8D1B 8D1A
read 8D3D 8D3C 8D1D 8D1C 8D3F 8D3E 8D1F 8D1E
read 8D41 8D40 8D21 8D20 8D43 8D42 8D23 8D22
read 8D45 8D44 8D25 8D24 8D47 8D46 8D27 8D26
read 8D49 8D48 8D29 8D28 8D4B 8D4A 8D2B 8D2A
read 8D4D 8D4C 8D2D 8D2C 8D4F 8D4E 8D2F 8D2E
read 8D51 8D50 8D31 8D30 8D53 8D52 8D33 8D32
fetch 000800 0 1 busy_request_ignored
read 2000 2001 2002 2003 2004 2005 2006 2007
read 2008 2009 200A 200B 200C 200D 200E 200F
fetch 003000 0 0 partial_read
read C000 C001 C002 C003 C004 C005 C006 C007
fetch 003010 0 0 restart_after_partial
read C040 C041 C042 C043 C044 C045 C046 C047
read C048 C049 C04A C04B C04C C04D C04E C04F
fetch 000040 1 0 far_low_sprite
read 0121 0120 0101 0100 0123 0122 0103 0102
read 0125 0124 0105 0104 0127 0126 0107 0106
read 0129 0128 0109 0108 012B 012A 010B 010A
read 012D 012C 010D 010C 012F 012E 010F 010E
read 0131 0130 0111 0110 0133 0132 0113 0112
read 0135 0134 0115 0114 0137 0136 0117 0116
read 0139 0138 0119 0118 013B 013A 011B 011A
read 013D 013C 011D 011C 013F 013E 011F 011E
fetch 3FFFF8 0 0 far_high_tile
read FFE0 FFE1 FFE2 FFE3 FFE4 FFE5 FFE6 FFE7
read FFE8 FFE9 FFEA FFEB FFEC FFED FFEE FFEF
read FFF0 FFF1 FFF2 FFF3 FFF4 FFF5 FFF6 FFF7
read FFF8 FFF9 FFFA FFFB FFFC FFFD FFFE FFFF
read 0000 0001 0002 0003 0004 0005 0006 0007
read 0008 0009 000A 000B 000C 000D 000E 000F
read 0010 0011 0012 0013 0014 0015 0016 0017
read 0018 0019 001A 001B 001C 001D 001E 001F

/* tb.f */
rom_cache_pkg.sv
dual_port_ram.sv
burst_buffer.sv
burst_fetcher.sv
rom_cache.sv
tb_mem_model.sv
tb_rom_cache.sv

/* tb_mem_model.sv */
module tb_mem_model
	import rom_cache_pkg::*;
#(
	parameter int burst_words = burst_words_default,
	parameter int latency     = 4,
	parameter int seed        = 1,
	parameter int drive_delay = 5
) (
	input  logic      clock,
	input  logic      reset,

	input  logic      mem_rd,
	input  rom_addr_t mem_addr,
	output logic      mem_valid,
	output rom_word_t mem_data
);

	// lane l of word k in a burst from address A holds the low 16 bits of
	// (A + k) * 4 + l, so every halfword in ROM carries its own index.
	function automatic rom_word_t word_at(input rom_addr_t base, input int k);
		rom_word_t   w;
		logic [31:0] n;
		w = '0;
		for (int l = 0; l < 4; l++) begin
			n = 32'((int'(base) + k) * 4 + l);
			w[16*l +: 16] = n[15:0];
		end
		return w;
	endfunction

	task automatic next_cycle;
		@(posedge clock);
		#drive_delay;
	endtask

	// one burst at a time, with random idle cycles between the words.
	initial begin
		rom_addr_t base;
		int        gap;
		mem_valid = 1'b0;
		mem_data = '0;
		void'($urandom(seed));
		forever begin
			next_cycle();
			if (!reset && mem_rd) begin
				base = mem_addr;
				repeat (latency) next_cycle();
				for (int k = 0; k < burst_words; k++) begin
					gap = $urandom_range(3, 0);
					repeat (gap) begin
						mem_valid = 1'b0;
						next_cycle();
					end
					mem_valid = 1'b1;
					mem_data = word_at(base, k);
					next_cycle();
				end
				mem_valid = 1'b0;
			end
		end
	end

endmodule

/* tb_rom_cache.sv */
module tb_rom_cache
	import rom_cache_pkg::*;
();

	localparam int clock_period   = 40;
	localparam int reset_cycles   = 8;
	localparam int drive_delay    = 5;
	localparam int mem_seed       = 4684;
	localparam int mem_latency    = 4;
	localparam int burst_words    = burst_words_default;
	localparam int reads_per_line = 8;
	localparam int ready_limit    = burst_words * 4 + 100;

	logic        clock = 1'b0;
	logic        reset;
	logic        fetch_req;
	rom_addr_t   fetch_addr;
	logic        fetch_sprite;
	logic        busy;
	logic        ready;
	logic        mem_rd;
	rom_addr_t   mem_addr;
	logic        mem_valid;
	rom_word_t   mem_data;
	logic        rd;
	pixel_word_t q;

	string       test_name[$];
	rom_addr_t   test_addr[$];
	bit          test_sprite[$];
	bit          test_collide[$];
	int          test_first[$];
	int          test_count[$];
	pixel_word_t expected[$];

	int mem_rd_count    = 0;
	int buf_wr_count    = 0;
	int test_errors     = 0;
	int pass_count      = 0;
	int fail_count      = 0;
	int setup_errors    = 0;
	int watchdog_cycles = 0;

	always #(clock_period / 2) clock = ~clock;

	rom_cache #(
		.burst_words       (burst_words),
		.buffer_addr_width (buffer_addr_width_default)
	) u_rom_cache (
		.clock        (clock),
		.reset        (reset),
		.fetch_req    (fetch_req),
		.fetch_addr   (fetch_addr),
		.fetch_sprite (fetch_sprite),
		.busy         (busy),
		.ready        (ready),
		.mem_rd       (mem_rd),
		.mem_addr     (mem_addr),
		.mem_valid    (mem_valid),
		.mem_data     (mem_data),
		.rd           (rd),
		.q            (q)
	);

	tb_mem_model #(
		.burst_words (burst_words),
		.latency     (mem_latency),
		.seed        (mem_seed),
		.drive_delay (drive_delay)
	) u_mem_model (
		.clock     (clock),
		.reset     (reset),
		.mem_rd    (mem_rd),
		.mem_addr  (mem_addr),
		.mem_valid (mem_valid),
		.mem_data  (mem_data)
	);

	// strobes are counted on the falling edge, where they are stable.
	always @(negedge clock) begin
		if (!reset) begin
			if (mem_rd) begin
				mem_rd_count++;
			end
			if (u_rom_cache.buf_wr) begin
				buf_wr_count++;
			end
		end
	end

	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clock);
		$display("the run timed out after %0d cycles", watchdog_cycles);
		$display("tests failed");
		$finish;
	end

	task automatic next_cycle;
		@(posedge clock);
		#drive_delay;
	endtask

	task automatic load_stimulus;
		int          fd;
		int          n;
		int          c;
		int          sprite_flag;
		int          collide_flag;
		int          last;
		rom_addr_t   addr;
		pixel_word_t value;
		string       token;
		string       name;
		fd = $fopen("rom_cache_stimulus.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file rom_cache_stimulus.txt");
			setup_errors++;
		end else begin
			while (!$feof(fd)) begin
				n = $fscanf(fd, "%s", token);
				if (n == 1) begin
					if (token == "#") begin
						c = $fgetc(fd);
						while (c != 10 && c != -1) begin
							c = $fgetc(fd);
						end
					end else if (token == "fetch") begin
						n = $fscanf(fd, "%h %d %d %s", addr, sprite_flag, collide_flag, name);
						if (n != 4) begin
							$display("a fetch line in the stimulus file is incomplete");
							setup_errors++;
						end else begin
							test_name.push_back(name);
							test_addr.push_back(addr);
							test_sprite.push_back(sprite_flag != 0);
							test_collide.push_back(collide_flag != 0);
							test_first.push_back(expected.size());
							test_count.push_back(0);
						end
					end else if (token == "read" && test_name.size() > 0) begin
						last = test_name.size() - 1;
						for (int i = 0; i < reads_per_line; i++) begin
							n = $fscanf(fd, "%h", value);
							expected.push_back(value);
						end
						test_count[last] += reads_per_line;
					end else begin
						$display("unexpected word %0s in the stimulus file", token);
						setup_errors++;
					end
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic run_fetch(input string name, input rom_addr_t addr, input bit sprite,
			input bit collide);
		int rd_before;
		int wr_before;
		int waited;
		rd_before = mem_rd_count;
		wr_before = buf_wr_count;
		fetch_req = 1'b1;
		fetch_addr = addr;
		fetch_sprite = sprite;
		next_cycle();
		fetch_req = 1'b0;
		if (mem_rd !== 1'b1) begin
			$display("** Error: mem_rd in test %0s: expected 1, got %h", name, mem_rd);
			test_errors++;
		end
		if (mem_addr !== addr) begin
			$display("** Error: mem_addr in test %0s: expected %h, got %h", name, addr, mem_addr);
			test_errors++;
		end
		if (busy !== 1'b1 || ready !== 1'b0) begin
			$display("** Error: busy/ready in test %0s: expected 1/0, got %h/%h",
				name, busy, ready);
			test_errors++;
		end
		// a second request during the burst must be dropped.
		if (collide) begin
			fetch_req = 1'b1;
			fetch_addr = ~addr;
			fetch_sprite = ~sprite;
			next_cycle();
			fetch_req = 1'b0;
		end
		waited = 0;
		while (ready !== 1'b1 && waited < ready_limit) begin
			next_cycle();
			waited++;
		end
		if (ready !== 1'b1) begin
			$display("test %0s: ready did not rise within %0d cycles", name, ready_limit);
			test_errors++;
		end
		next_cycle();
		next_cycle();
		if (mem_rd_count - rd_before != 1) begin
			$display("** Error: mem_rd pulses in test %0s: expected %h, got %h",
				name, 1, mem_rd_count - rd_before);
			test_errors++;
		end
		if (buf_wr_count - wr_before != burst_words) begin
			$display("** Error: buf_wr pulses in test %0s: expected %h, got %h",
				name, burst_words, buf_wr_count - wr_before);
			test_errors++;
		end
	endtask

	// q is checked, then rd moves the pointer on and two edges later q
	// shows the next halfword.
	task automatic check_reads(input string name, input int first, input int count);
		for (int k = 0; k < count; k++) begin
			if (q !== expected[first + k]) begin
				$display("** Error: q in test %0s, read %0d: expected %h, got %h",
					name, k, expected[first + k], q);
				test_errors++;
			end
			rd = 1'b1;
			next_cycle();
			rd = 1'b0;
			next_cycle();
		end
	endtask

	task automatic finish_test(input string name);
		if (test_errors == 0) begin
			pass_count++;
			$display("test %0s: pass", name);
		end else begin
			fail_count++;
			$display("test %0s: fail with %0d errors", name, test_errors);
		end
		test_errors = 0;
	endtask

	initial begin
		reset = 1'b1;
		fetch_req = 1'b0;
		fetch_addr = '0;
		fetch_sprite = 1'b0;
		rd = 1'b0;
		load_stimulus();
		watchdog_cycles = test_name.size() * (burst_words * 4 + 300);
		repeat (reset_cycles) @(posedge clock);
		#drive_delay;
		reset = 1'b0;

		if (busy !== 1'b0 || ready !== 1'b0 || mem_rd !== 1'b0) begin
			$display("** Error: busy/ready/mem_rd after reset: expected 0/0/0, got %h/%h/%h",
				busy, ready, mem_rd);
			test_errors++;
		end
		finish_test("reset_state");

		for (int t = 0; t < test_name.size(); t++) begin
			run_fetch(test_name[t], test_addr[t], test_sprite[t], test_collide[t]);
			check_reads(test_name[t], test_first[t], test_count[t]);
			finish_test(test_name[t]);
		end

		$display("summary: %0d passed, %0d failed, %0d stimulus errors",
			pass_count, fail_count, setup_errors);
		if (fail_count == 0 && setup_errors == 0 && test_name.size() > 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule
